// File: hw/qupls_pkg.sv
/*
 * Shared definitions for the immediate decode stage
 *  - fetch window size, postfix enable and float precision code
 *  - instruction word views, window type and decode result type
 *  - major opcode values used by the immediate decoder
 */
package qupls_pkg;

	// ========================================
	// Sizes and feature switches
	// ========================================

	// Number of instruction words that fetch presents in one window
	localparam int WINDOW_WORDS = 6;

	// Postfix words are only decoded while this is set
	localparam logic SUPPORT_POSTFIX = 1'b1;

	// Precision field code that selects IEEE double on float ops
	localparam logic [1:0] FLT_PREC_DOUBLE = 2'd2;

	// ========================================
	// Instruction word
	// ========================================

	// Major opcode sits in the low seven bits of every word
	typedef logic [6:0] opcode_t;

	// Postfix view: a 32-bit payload above one spare bit
	typedef struct packed {
		logic [31:0] b39_8;
		logic        b7;
	} pfx_view_t;

	// Short immediate view used by the base immediate opcodes
	typedef struct packed {
		logic [20:0] b39_19;
		logic [11:0] b18_7;
	} imm_view_t;

	// Float view, only the precision field matters here
	typedef struct packed {
		logic [12:0] b39_27;
		logic [1:0]  b26_25;
		logic [17:0] b24_7;
	} flt_view_t;

	// The upper 33 bits seen through whichever format applies
	typedef union packed {
		pfx_view_t pfx;
		imm_view_t imm;
		flt_view_t flt;
	} ins_upper_t;

	// A full 40-bit instruction word
	typedef struct packed {
		ins_upper_t upper;
		opcode_t    opcode;
	} instruction_t;

	// Fetch window, word 0 holds the base instruction
	typedef instruction_t [WINDOW_WORDS-1:0] ins_window_t;

	typedef logic [63:0] imm64_t;

	// Decoded immediates, presence flags and words consumed
	typedef struct packed {
		imm64_t     imma;
		imm64_t     immb;
		imm64_t     immc;
		logic       has_imma;
		logic       has_immb;
		logic       has_immc;
		logic [2:0] length;
	} imm_result_t;

	// ========================================
	// Opcodes
	// ========================================

	localparam opcode_t OP_ADDI   = 7'h04;
	localparam opcode_t OP_CMPI   = 7'h05;
	localparam opcode_t OP_CSR    = 7'h07;
	localparam opcode_t OP_ANDI   = 7'h08;
	localparam opcode_t OP_ORI    = 7'h09;
	localparam opcode_t OP_ADDSI  = 7'h0C;
	localparam opcode_t OP_ANDSI  = 7'h0D;
	localparam opcode_t OP_ORSI   = 7'h0E;
	localparam opcode_t OP_FLT3   = 7'h11;
	localparam opcode_t OP_BCC    = 7'h28;
	localparam opcode_t OP_LDO    = 7'h4B;
	localparam opcode_t OP_STO    = 7'h53;
	localparam opcode_t OP_LDAX   = 7'h5C;
	localparam opcode_t OP_FENCE  = 7'h6F;
	// Postfix and qualifier words never start an instruction
	localparam opcode_t OP_PFXA32 = 7'h70;
	localparam opcode_t OP_PFXB32 = 7'h74;
	localparam opcode_t OP_PFXC32 = 7'h78;
	localparam opcode_t OP_VEC    = 7'h7C;

endpackage

// File: hw/fp_cvt32_to_64.sv
/*
 * IEEE single to IEEE double widener, purely combinational
 *  - normal values get a rebiased exponent and a left aligned fraction
 *  - subnormals are normalized with a leading zero count
 *  - signed zero, infinity and NaN payloads pass through
 */
module fp_cvt32_to_64
(
	input  logic [31:0]       src,
	output qupls_pkg::imm64_t dst
);

	// Fields of the single precision source
	logic        sgn;
	logic [7:0]  exp_s;
	logic [22:0] frac_s;
	// Leading zeros in a subnormal fraction
	logic [4:0]  lz;
	// Subnormal fraction with the hidden one shifted out
	logic [22:0] frac_n;

	// Counts zeros above the highest set bit, 23 when the input is zero
	function automatic logic [4:0] lzc23(input logic [22:0] v);
		logic [4:0] cnt;
		cnt = 5'd23;
		// Scanning upward lets the highest set bit win
		for (int i = 0; i < 23; i++)
		begin
			if (v[i])
				cnt = 5'(22 - i);
		end
		return cnt;
	endfunction

	assign sgn    = src[31];
	assign exp_s  = src[30:23];
	assign frac_s = src[22:0];

	assign lz = lzc23(frac_s);
	// The leading one lands just above bit 22 and is dropped
	assign frac_n = frac_s << (lz + 5'd1);

	// ========================================
	// Result select
	// ========================================
	always_comb
	begin
		if (exp_s == 8'hFF)
			// Infinity and NaN keep the payload in the top fraction bits
			dst = {sgn, 11'h7FF, frac_s, 29'd0};
		else if (exp_s == 8'h00 && frac_s == 23'd0)
			// Zero keeps its sign
			dst = {sgn, 63'd0};
		else if (exp_s == 8'h00)
			// A subnormal with its top bit at 22 is 2**-127, biased 896
			dst = {sgn, 11'd896 - {6'd0, lz}, frac_n, 29'd0};
		else
			// The bias moves from 127 to 1023
			dst = {sgn, {3'd0, exp_s} + 11'd896, frac_s, 29'd0};
	end

endmodule

// File: hw/decode_imm.sv
/*
 * Immediate decoder over one fetch window, purely combinational
 *  - base word immediates with per opcode extension rules
 *  - in order A, B, C postfix scan after an optional VEC word
 *  - three single to double wideners for float postfixes
 *  - length of the instruction in window words
 */
module decode_imm
(
	input  logic                   clk,
	input  qupls_pkg::ins_window_t ins,
	output qupls_pkg::imm_result_t res
);
	import qupls_pkg::*;

	instruction_t base;
	// Set for a three operand float op at double precision
	logic flt_dbl;
	// Immediates taken from the base word alone
	imm64_t base_b;
	imm64_t base_c;
	logic base_has_b;
	logic base_has_c;
	// Scan state, one entry per slot with A in entry 0
	logic [2:0] has_pfx;
	logic [2:0] has_hi;
	logic [2:0][2:0] pfx_pos;
	// Index of the next word to look at, ends up as the length
	logic [2:0] ndx;
	logic [2:0][31:0] cvt_src;
	imm64_t [2:0] cvt_dst;
	imm64_t [2:0] slot_imm;

	// Postfix opcode belonging to a slot
	function automatic opcode_t pfx_op(input int s);
		case (s)
		0: return OP_PFXA32;
		1: return OP_PFXB32;
		default: return OP_PFXC32;
		endcase
	endfunction

	// True when the word at idx exists and carries op
	function automatic logic op_at(input ins_window_t w, input logic [2:0] idx,
		input opcode_t op);
		logic hit;
		hit = 1'b0;
		if (idx < 3'(WINDOW_WORDS))
			hit = (w[idx].opcode == op);
		return hit;
	endfunction

	assign base = ins[0];
	assign flt_dbl = (base.opcode == OP_FLT3) && (base.upper.flt.b26_25 == FLT_PREC_DOUBLE);

	// ========================================
	// Base word decode
	// ========================================
	always_comb
	begin
		base_b = '0;
		base_c = '0;
		base_has_b = 1'b1;
		base_has_c = 1'b0;
		case (base.opcode)
		OP_ADDI, OP_CMPI, OP_LDO, OP_STO:
			base_b = {{43{base[39]}}, base.upper.imm.b39_19};
		OP_ANDI:
			base_b = {{43{1'b1}}, base.upper.imm.b39_19};
		OP_ORI:
			base_b = {43'd0, base.upper.imm.b39_19};
		OP_ADDSI:
			base_b = {{40{base[39]}}, base[39:16]};
		// Logical short forms fill so the unused upper bits are neutral
		OP_ANDSI:
			base_b = {{40{1'b1}}, base[39:16]};
		OP_ORSI:
			base_b = {40'd0, base[39:16]};
		OP_CSR:
			base_b = {53'd0, base[29:19]};
		OP_LDAX:
			base_b = {{56{base[34]}}, base[34:27]};
		OP_FENCE:
			base_b = {48'd0, base[23:8]};
		OP_BCC:
		begin
			// Branch displacement is split around the condition field
			base_c = {{47{base[39]}}, base[39:25], base[12:11]};
			base_has_b = 1'b0;
			base_has_c = 1'b1;
		end
		default:
			base_has_b = 1'b0;
		endcase
	end

	// ========================================
	// Postfix scan
	// ========================================
	always_comb
	begin
		has_pfx = '0;
		has_hi = '0;
		pfx_pos = '0;
		ndx = 3'd1;
		// One vector qualifier may sit between the base and its postfixes
		if (op_at(ins, ndx, OP_VEC))
			ndx = ndx + 3'd1;
		if (SUPPORT_POSTFIX)
		begin
			// Slots must appear in A, B, C order, a slot out of order ends the scan
			for (int s = 0; s < 3; s++)
			begin
				if (op_at(ins, ndx, pfx_op(s)))
				begin
					has_pfx[s] = 1'b1;
					pfx_pos[s] = ndx;
					ndx = ndx + 3'd1;
					// A repeated postfix of the same slot supplies the upper half
					if (op_at(ins, ndx, pfx_op(s)))
					begin
						has_hi[s] = 1'b1;
						ndx = ndx + 3'd1;
					end
				end
			end
		end
	end

	// Each widener sees the payload of the first postfix of its slot
	always_comb
	begin
		for (int s = 0; s < 3; s++)
			cvt_src[s] = ins[pfx_pos[s]].upper.pfx.b39_8;
	end

	fp_cvt32_to_64 u_cvt_a
	(
		.src(cvt_src[0]),
		.dst(cvt_dst[0])
	);

	fp_cvt32_to_64 u_cvt_b
	(
		.src(cvt_src[1]),
		.dst(cvt_dst[1])
	);

	fp_cvt32_to_64 u_cvt_c
	(
		.src(cvt_src[2]),
		.dst(cvt_dst[2])
	);

	// ========================================
	// Slot values and result
	// ========================================
	always_comb
	begin
		for (int s = 0; s < 3; s++)
		begin
			slot_imm[s] = {{32{cvt_src[s][31]}}, cvt_src[s]};
			if (flt_dbl)
				slot_imm[s] = cvt_dst[s];
			if (has_hi[s])
				slot_imm[s][63:32] = ins[pfx_pos[s] + 3'd1].upper.pfx.b39_8;
		end
	end

	// A postfix wins over a base immediate in the same slot
	always_comb
	begin
		res.imma = has_pfx[0] ? slot_imm[0] : '0;
		res.immb = has_pfx[1] ? slot_imm[1] : base_b;
		res.immc = has_pfx[2] ? slot_imm[2] : base_c;
		res.has_imma = has_pfx[0];
		res.has_immb = has_pfx[1] | base_has_b;
		res.has_immc = has_pfx[2] | base_has_c;
		res.length = ndx;
	end

	// Fetch must always advance and never past the window
	a_length_range: assert property (@(posedge clk)
		res.length >= 3'd1 && res.length <= 3'(WINDOW_WORDS));

	// Slot A only ever comes from a postfix word
	a_imma_needs_pfx: assert property (@(posedge clk) res.has_imma |-> res.length >= 3'd2);

endmodule

// File: hw/imm_decode_stage.sv
/*
 * Immediate decode stage, top level
 *  - window register loaded on the input strobe
 *  - combinational immediate decoder
 *  - result register with a one cycle valid pulse
 */
module imm_decode_stage
(
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   in_valid,
	input  qupls_pkg::ins_window_t window,
	output logic                   out_valid,
	output qupls_pkg::imm_result_t result
);
	import qupls_pkg::*;

	// First stage holds the sampled window
	ins_window_t window_q;
	logic stage_valid;
	// Decoder output ahead of the result register
	imm_result_t dec_res;

	// ========================================
	// Window register
	// ========================================
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			window_q <= '0;
			stage_valid <= 1'b0;
		end
		else
		begin
			// Valid follows the strobe every cycle, so it is a single pulse
			stage_valid <= in_valid;
			if (in_valid)
				window_q <= window;
		end
	end

	decode_imm u_decode_imm
	(
		.clk(clk),
		.ins(window_q),
		.res(dec_res)
	);

	// ========================================
	// Result register
	// ========================================
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			result <= '0;
			out_valid <= 1'b0;
		end
		else
		begin
			// No back-pressure, the consumer takes the result on out_valid
			out_valid <= stage_valid;
			if (stage_valid)
				result <= dec_res;
		end
	end

	// Each decoded window leaves exactly one cycle after it was staged
	a_out_follows_stage: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid == $past(stage_valid));

endmodule

// File: bench/tb_imm_decode_stage.sv
/*
 * Testbench for the immediate decode stage
 *  - clock, reset and vector file reader
 *  - stimulus with random idle gaps and a queue of expected results
 *  - compare tasks for immediates, flags, length and latency
 *  - closing error count and verdict
 */
module tb_imm_decode_stage;
	timeunit 1ns;
	timeprecision 1ps;
	import qupls_pkg::*;

	localparam int NUM_VECTORS = 28;
	// Six window words, three immediates, then flags and length in one value
	localparam int COLS = 10;
	localparam int RESULT_TIMEOUT = 20;
	// Edges from the edge that samples in_valid to the edge that raises out_valid
	localparam int LATENCY = 2;

	logic clk;
	logic arst_n;
	logic in_valid;
	ins_window_t window;
	logic out_valid;
	imm_result_t result;

	logic [63:0] vec_mem [NUM_VECTORS*COLS];
	// Expected results in issue order, with vector index and the edge count before sampling
	imm_result_t exp_q [$];
	int name_q [$];
	int edge_q [$];
	int edges = 0;
	int seed = 14003;
	int mismatches = 0;
	int timeouts = 0;
	int other_errors = 0;

	imm_decode_stage u_imm_decode_stage
	(
		.clk(clk),
		.arst_n(arst_n),
		.in_valid(in_valid),
		.window(window),
		.out_valid(out_valid),
		.result(result)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Processes woken by an edge still see the count from before it
	always @(posedge clk)
		edges <= edges + 1;

	// ========================================
	// Compare tasks
	// ========================================
	task automatic compare_imm(input string name, input string field, input imm64_t exp_v,
		input imm64_t act_v);
		if (act_v !== exp_v)
		begin
			$display("Fail %s %s expected %h actual %h", name, field, exp_v, act_v);
			mismatches++;
		end
	endtask

	// Flags are ordered A, B, C from the top bit down
	task automatic compare_flags(input string name, input logic [2:0] exp_v,
		input logic [2:0] act_v);
		if (act_v !== exp_v)
		begin
			$display("Fail %s flags expected %b actual %b", name, exp_v, act_v);
			mismatches++;
		end
	endtask

	task automatic compare_length(input string name, input logic [2:0] exp_v,
		input logic [2:0] act_v);
		if (act_v !== exp_v)
		begin
			$display("Fail %s length expected %0d actual %0d", name, exp_v, act_v);
			mismatches++;
		end
	endtask

	task automatic compare_latency(input string name, input int exp_v, input int act_v);
		if (act_v != exp_v)
		begin
			$display("Fail %s latency expected %0d actual %0d", name, exp_v, act_v);
			mismatches++;
		end
	endtask

	// Absent immediates have no defined value, so only present ones are checked
	task automatic check_result(input string name, input imm_result_t exp_r,
		input imm_result_t act_r);
		if (exp_r.has_imma)
			compare_imm(name, "imma", exp_r.imma, act_r.imma);
		if (exp_r.has_immb)
			compare_imm(name, "immb", exp_r.immb, act_r.immb);
		if (exp_r.has_immc)
			compare_imm(name, "immc", exp_r.immc, act_r.immc);
		compare_flags(name, {exp_r.has_imma, exp_r.has_immb, exp_r.has_immc},
			{act_r.has_imma, act_r.has_immb, act_r.has_immc});
		compare_length(name, exp_r.length, act_r.length);
	endtask

	// ========================================
	// Stimulus
	// ========================================
	task automatic issue_vector(input int v);
		ins_window_t w;
		imm_result_t e;
		logic [63:0] fl;
		int b;
		b = v * COLS;
		for (int i = 0; i < WINDOW_WORDS; i++)
			w[i] = vec_mem[b + i][39:0];
		e.imma = vec_mem[b + 6];
		e.immb = vec_mem[b + 7];
		e.immc = vec_mem[b + 8];
		// High nibble holds the A, B, C flags and the low nibble the length
		fl = vec_mem[b + 9];
		e.has_imma = fl[6];
		e.has_immb = fl[5];
		e.has_immc = fl[4];
		e.length = fl[2:0];
		@(posedge clk);
		in_valid <= 1'b1;
		window <= w;
		exp_q.push_back(e);
		name_q.push_back(v);
		// The DUT samples the strobe one edge after this one
		// Kept here is the count as it stands just before that sampling edge
		edge_q.push_back(edges + 1);
	endtask

	task automatic drive_all();
		int r;
		for (int v = 0; v < NUM_VECTORS; v++)
		begin
			issue_vector(v);
			r = $random(seed);
			// Mix back-to-back issue with single idle cycles
			if (r[0])
			begin
				@(posedge clk);
				in_valid <= 1'b0;
			end
		end
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	// ========================================
	// Response side
	// ========================================
	task automatic wait_output(output logic seen);
		int cycles;
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < RESULT_TIMEOUT)
		begin
			@(negedge clk);
			seen = out_valid;
			cycles++;
		end
	endtask

	task automatic collect_all();
		logic seen;
		imm_result_t e;
		string name;
		int sample_edge;
		for (int n = 0; n < NUM_VECTORS; n++)
		begin
			wait_output(seen);
			if (!seen)
			begin
				$display("No result arrived within %0d cycles for result %0d",
					RESULT_TIMEOUT, n);
				timeouts++;
				return;
			end
			if (exp_q.size() == 0)
			begin
				$display("out_valid rose while no window was in flight");
				other_errors++;
				return;
			end
			e = exp_q.pop_front();
			name = $sformatf("vec%0d", name_q.pop_front());
			sample_edge = edge_q.pop_front();
			check_result(name, e, result);
			compare_latency(name, LATENCY, edges - sample_edge);
		end
	endtask

	// out_valid must stay low while nothing is in flight
	task automatic check_idle(input string name, input int cycles);
		repeat (cycles)
		begin
			@(negedge clk);
			if (out_valid !== 1'b0)
			begin
				$display("out_valid was high with no window in flight during %s", name);
				other_errors++;
			end
		end
	endtask

	// ========================================
	// Main sequence
	// ========================================
	initial
	begin
		arst_n <= 1'b0;
		in_valid <= 1'b0;
		window <= '0;
		$readmemh("bench/imm_decode_vectors.txt", vec_mem);
		// Every vector consumes at least one word, so a zero length marks a short file
		if ($isunknown(vec_mem[NUM_VECTORS*COLS-1]) ||
			vec_mem[NUM_VECTORS*COLS-1][2:0] == 3'd0)
		begin
			$display("Vector file is missing or holds fewer than %0d vectors", NUM_VECTORS);
			other_errors++;
		end
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		check_idle("reset", 3);
		// Result register comes out of reset cleared
		compare_imm("reset", "imma", '0, result.imma);
		compare_imm("reset", "immb", '0, result.immb);
		compare_imm("reset", "immc", '0, result.immc);
		compare_flags("reset", 3'b000, {result.has_imma, result.has_immb, result.has_immc});
		compare_length("reset", 3'd0, result.length);
		if (other_errors == 0)
		begin
			fork
				drive_all();
				collect_all();
			join
			check_idle("drain", 4);
		end
		$display("Errors: %0d mismatches, %0d timeouts, %0d other", mismatches, timeouts,
			other_errors);
		if (mismatches == 0 && timeouts == 0 && other_errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: imm_decode_stage.f
hw/qupls_pkg.sv
hw/fp_cvt32_to_64.sv
hw/decode_imm.sv
hw/imm_decode_stage.sv
bench/tb_imm_decode_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the immediate decode stage testbench with Verilator and runs it.
# The run counts as passed only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_imm_decode_stage
LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps \
	--top-module tb_imm_decode_stage \
	-Mdir "$BUILD_DIR" -o "$SIM_BIN" \
	-f imm_decode_stage.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation binary exited with status $status"
	exit 1
fi

if grep -qx "SIMULATION PASSED" "$LOG"; then
	exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// File: bench/imm_decode_vectors.txt
// Columns: w0 w1 w2 w3 w4 w5 imma immb immc flags, all hex, w0 is the base word
// flags: high nibble has_imma=4 has_immb=2 has_immc=1, low nibble is the length
// Base immediates: ADDI CMPI LDO STO ANDI ORI ADDSI ANDSI ORSI CSR LDAX FENCE BCC BCC none
9180004 0 0 0 0 0 0 123 0 21
FFFF800005 0 0 0 0 0 0 FFFFFFFFFFFFFFF0 0 21
7FFFF8004B 0 0 0 0 0 0 FFFFF 0 21
8000000053 0 0 0 0 0 0 FFFFFFFFFFF00000 0 21
55E00008 0 0 0 0 0 0 FFFFFFFFFFE00ABC 0 21
FFFF800009 0 0 0 0 0 0 1FFFF0 0 21
800001000C 0 0 0 0 0 0 FFFFFFFFFF800001 0 21
123456000D 0 0 0 0 0 0 FFFFFFFFFF123456 0 21
FEDCBA000E 0 0 0 0 0 0 FEDCBA 0 21
FFFFF80007 0 0 0 0 0 0 7FF 0 21
42800005C 0 0 0 0 0 0 FFFFFFFFFFFFFF85 0 21
BEEF6F 0 0 0 0 0 0 BEEF 0 21
8002001028 0 0 0 0 0 0 0 FFFFFFFFFFFF0006 11
6000828 0 0 0 0 0 0 0 D 11
0 0 0 0 0 0 0 0 0 1
// Single postfixes: A alone, B over an ADDI base, then A B C
2 8000000170 0 0 0 0 FFFFFFFF80000001 0 0 42
9180004 7FFFFFFF74 0 0 0 0 0 7FFFFFFF 0 22
2 1111111170 F222222274 3333333378 0 0 11111111 FFFFFFFFF2222222 33333333 74
// Doubled postfixes and VEC qualifier
2 89ABCDEF70 123456770 0 0 0 123456789ABCDEF 0 0 43
2 7C 1074 FFFFFFFF74 8000000078 0 0 FFFFFFFF00000010 FFFFFFFF80000000 35
2 7C AAAAAAAA70 5555555570 1234567874 9ABCDEF074 55555555AAAAAAAA 9ABCDEF012345678 0 66
BEEF6F 7C 0 0 0 0 0 BEEF 0 22
// FLT3 double: normal, subnormals, signed zeros, inf and NaN, then single precision
4000011 3F80000070 C020000074 0 0 0 3FF0000000000000 C004000000000000 0 63
4000011 170 30000074 8040000078 0 0 36A0000000000000 37F8000000000000 B800000000000000 74
4000011 8000000070 74 0 0 0 8000000000000000 0 0 63
4000011 7F80000070 FFC0000174 0 0 0 7FF0000000000000 FFF8000020000000 0 63
2000011 C020000074 0 0 0 0 0 FFFFFFFFC0200000 0 22
// B postfix ahead of an A postfix, the A word is not consumed
2 574 670 0 0 0 0 5 0 22
